/* Bender.yml */
package:
  name: zbt_frame_buffer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fb_pkg.sv
      - design/fb_ifs.sv
      - design/raster_timer.sv
      - design/clear_sequencer.sv
      - design/apb_pixel_port.sv
      - design/slot_arbiter.sv
      - design/display_fetch.sv
      - design/zbt_frame_buffer.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_zbt_frame_buffer.sv

/* design/apb_pixel_port.sv */
////////////////////////////////////////
// APB slave, no wait states on registers
// data writes wait for a memory write slot
// data register is write only
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module apb_pixel_port (
   input logic clk,
   input logic reset,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input logic [3:0] paddr,
   input logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic pready,
   output logic pslverr,
   output fb_pkg::offset_t offset,
   wr_req_if.client req
);
   import fb_pkg::*;

   mem_addr_t word_addr;
   logic access;
   logic sel_offset;
   logic sel_addr;
   logic sel_data;
   logic bad_access;

   // address decode
   always_comb begin
      access = psel && penable;
      sel_offset = (paddr == `FB_REG_OFFSET);
      sel_addr = (paddr == `FB_REG_ADDR);
      sel_data = (paddr == `FB_REG_DATA);
      // unknown address or a read of the data register
      bad_access = !(sel_offset || sel_addr || (sel_data && pwrite));
   end

   // pixel write request lives for the whole access phase
   assign req.valid = access && sel_data && pwrite;
   assign req.addr = word_addr;
   assign req.data = pwdata;

   // register accesses end at once, data writes end on grant
   assign pready = access && (!req.valid || req.grant);
   assign pslverr = access && bad_access;

   always_comb begin
      case (paddr)
         `FB_REG_OFFSET: prdata = 32'(offset);
         `FB_REG_ADDR: prdata = 32'(word_addr);
         default: prdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         offset <= '0;
         word_addr <= '0;
      end else if (access && pwrite) begin
         if (sel_offset) begin
            offset <= pwdata[$bits(offset_t)-1:0];
         end
         if (sel_addr) begin
            word_addr <= pwdata[$bits(mem_addr_t)-1:0];
         end
         // post-increment after each stored group
         if (req.grant) begin
            word_addr <= word_addr + 1'b1;
         end
      end
   end

   // host request must hold still until the arbiter takes it
   a_req_held : assert property (@(posedge clk) disable iff (reset)
      req.valid && !req.grant |=> req.valid && $stable(req.addr) && $stable(req.data))
      else $error("host write request changed before its grant");

endmodule

/* design/clear_sequencer.sv */
////////////////////////////////////////
// zero-fills the frame on an offset change
// one word per granted write slot
// a change while clearing restarts at word 0
////////////////////////////////////////
`timescale 1ns/1ps

module clear_sequencer #(
   // default is the XGA frame in 36-bit words
   parameter int frame_words = 196608
) (
   input logic clk,
   input logic reset,
   input fb_pkg::offset_t offset,
   wr_req_if.client req
);
   import fb_pkg::*;

   clear_state_t state;
   offset_t last_offset;
   mem_addr_t word_addr;
   logic changed;
   logic last_word;

   assign changed = (offset != last_offset);
   assign last_word = (word_addr == mem_addr_t'(frame_words - 1));

   // request zero data for the current word
   assign req.valid = (state == clearing);
   assign req.addr = word_addr;
   assign req.data = '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
         last_offset <= '0;
         word_addr <= '0;
      end else begin
         last_offset <= offset;
         if (changed) begin
            state <= clearing;
            word_addr <= '0;
         end else begin
            case (state)
               clearing: begin
                  // advance only when the arbiter takes the word
                  if (req.grant) begin
                     if (last_word) begin
                        state <= done;
                     end else begin
                        word_addr <= word_addr + 1'b1;
                     end
                  end
               end
               done: state <= idle;
               default: state <= idle;
            endcase
         end
      end
   end

   a_addr_in_frame : assert property (@(posedge clk) disable iff (reset)
      req.valid |-> (req.addr < frame_words))
      else $error("clear address beyond frame");

endmodule

/* design/display_fetch.sv */
////////////////////////////////////////
// one word read per group, low byte first
// video lags the raster by five clocks
// assumes read slot 0 and latency of 2 or less
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module display_fetch #(
   parameter int h_active = `FB_H_ACTIVE,
   parameter int h_total = `FB_H_ACTIVE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK
) (
   input logic clk,
   input logic reset,
   raster_if.sink raster,
   output fb_pkg::mem_addr_t read_addr,
   input fb_pkg::mem_word_t mem_rdata,
   output fb_pkg::pixel_t video_pixel,
   output logic video_hsync,
   output logic video_vsync,
   output logic video_blank
);
   import fb_pkg::*;

   localparam int line_words = h_active / 4;
   localparam logic [1:0] capture_slot = 2'((`FB_SLOT_READ + `FB_READ_LATENCY) % 4);
   // clocks from raster position to the pixel shifter
   localparam int lag = 4;

   mem_word_t word_q;
   logic [31:0] shift_q;
   logic [lag-1:0] hsync_d;
   logic [lag-1:0] vsync_d;
   logic [lag-1:0] blank_d;

   // group under the raster, fetched one group ahead of the video
   // groups past h_active fall in blanking and are never shown
   assign read_addr = mem_addr_t'(raster.vcount * line_words)
                    + mem_addr_t'(raster.hcount[10:2]);

   // capture the returned word, then load the shifter on slot 3
   always_ff @(posedge clk) begin
      if (raster.hcount[1:0] == capture_slot) begin
         word_q <= mem_rdata;
      end
      if (raster.hcount[1:0] == 2'd3) begin
         shift_q <= word_q[31:0];
      end else begin
         shift_q <= {8'h00, shift_q[31:8]};
      end
   end

   ////////////////////////////////////////
   // sync and blank delay, output stage
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         hsync_d <= '1;
         vsync_d <= '1;
         blank_d <= '1;
         video_pixel <= '0;
         video_hsync <= 1'b1;
         video_vsync <= 1'b1;
         video_blank <= 1'b1;
      end else begin
         hsync_d <= {hsync_d[lag-2:0], raster.hsync};
         vsync_d <= {vsync_d[lag-2:0], raster.vsync};
         blank_d <= {blank_d[lag-2:0], raster.blank};
         // black during blanking
         video_pixel <= blank_d[lag-1] ? '0 : shift_q[7:0];
         video_hsync <= hsync_d[lag-1];
         video_vsync <= vsync_d[lag-1];
         video_blank <= blank_d[lag-1];
      end
   end

   // raster must agree with the line length used here
   a_hcount_range : assert property (@(posedge clk) disable iff (reset)
      raster.hcount < h_total)
      else $error("hcount beyond horizontal total");

endmodule

/* design/fb_ifs.sv */
////////////////////////////////////////
// raster bus and write request channel
// sync is active low, blank active high
////////////////////////////////////////
`timescale 1ns/1ps

interface raster_if;
   import fb_pkg::*;

   hcount_t hcount;
   vcount_t vcount;
   logic hsync;
   logic vsync;
   logic blank;

   modport source (output hcount, vcount, hsync, vsync, blank);
   modport sink (input hcount, vcount, hsync, vsync, blank);
endinterface

interface wr_req_if;
   import fb_pkg::*;

   // client holds valid, addr and data until grant
   logic valid;
   mem_addr_t addr;
   logic [31:0] data;
   logic grant;

   modport client (output valid, addr, data, input grant);
   modport arbiter (input valid, addr, data, output grant);
endinterface

/* design/fb_macros.svh */
////////////////////////////////////////
// default raster sizes are XGA 1024x768
// horizontal total must be a multiple of 4
// slot numbers index hcount[1:0]
////////////////////////////////////////
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// horizontal raster, in pixels
`define FB_H_ACTIVE 1024
`define FB_H_FRONT 24
`define FB_H_SYNC 136
`define FB_H_BACK 160

// vertical raster, in lines
`define FB_V_ACTIVE 768
`define FB_V_FRONT 3
`define FB_V_SYNC 6
`define FB_V_BACK 29

// memory slots within each four-pixel group
`define FB_SLOT_READ 0
`define FB_SLOT_WRITE 2

// cycles from read address to read data
`define FB_READ_LATENCY 2

// apb register map
`define FB_REG_OFFSET 4'h0
`define FB_REG_ADDR 4'h4
`define FB_REG_DATA 4'h8

`endif

/* design/fb_pkg.sv */
////////////////////////////////////////
// shared types of the frame buffer
// memory word holds four pixels plus parity
////////////////////////////////////////
package fb_pkg;

   // one grey pixel
   typedef logic [7:0] pixel_t;

   // four pixels, parity in the top nibble
   typedef logic [35:0] mem_word_t;

   // word address of the 512k ZBT
   typedef logic [18:0] mem_addr_t;

   // raster position
   typedef logic [10:0] hcount_t;
   typedef logic [9:0] vcount_t;

   // view offset register
   typedef logic [5:0] offset_t;

   // clear sequencer FSM
   typedef enum logic [1:0] {
      idle,
      clearing,
      done
   } clear_state_t;

endpackage

/* design/raster_timer.sv */
////////////////////////////////////////
// one pixel per clock, no clock enable
// horizontal total must be a multiple of 4
// reset parks the raster at the last pixel
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module raster_timer #(
   parameter int h_active = `FB_H_ACTIVE,
   parameter int h_front = `FB_H_FRONT,
   parameter int h_sync = `FB_H_SYNC,
   parameter int h_back = `FB_H_BACK,
   parameter int v_active = `FB_V_ACTIVE,
   parameter int v_front = `FB_V_FRONT,
   parameter int v_sync = `FB_V_SYNC,
   parameter int v_back = `FB_V_BACK
) (
   input logic clk,
   input logic reset,
   raster_if.source raster
);
   import fb_pkg::*;

   localparam int h_total = h_active + h_front + h_sync + h_back;
   localparam int v_total = v_active + v_front + v_sync + v_back;
   localparam int h_sync_start = h_active + h_front;
   localparam int v_sync_start = v_active + v_front;

   hcount_t h_next;
   vcount_t v_next;
   logic line_end;

   // next position, vcount steps at each line wrap
   always_comb begin
      line_end = (raster.hcount == hcount_t'(h_total - 1));
      h_next = line_end ? '0 : raster.hcount + 1'b1;
      v_next = raster.vcount;
      if (line_end) begin
         v_next = (raster.vcount == vcount_t'(v_total - 1)) ? '0 : raster.vcount + 1'b1;
      end
   end

   // sync and blank are decoded from the next position
   // so they stay aligned with the registered counters
   always_ff @(posedge clk) begin
      if (reset) begin
         raster.hcount <= hcount_t'(h_total - 1);
         raster.vcount <= vcount_t'(v_total - 1);
         raster.hsync <= 1'b1;
         raster.vsync <= 1'b1;
         raster.blank <= 1'b1;
      end else begin
         raster.hcount <= h_next;
         raster.vcount <= v_next;
         raster.hsync <= !((h_next >= h_sync_start) && (h_next < h_sync_start + h_sync));
         raster.vsync <= !((v_next >= v_sync_start) && (v_next < v_sync_start + v_sync));
         raster.blank <= (h_next >= h_active) || (v_next >= v_active);
      end
   end

   // slot sharing needs whole four-pixel groups per line
   a_htotal_mod4 : assert property (@(posedge clk) (h_total % 4) == 0)
      else $error("horizontal total %0d is not a multiple of 4", h_total);

endmodule

/* design/slot_arbiter.sv */
////////////////////////////////////////
// one memory port shared by hcount[1:0]
// clear beats host on the write slot
// idle slots carry the display address
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module slot_arbiter (
   input logic clk,
   raster_if.sink raster,
   wr_req_if.arbiter clear_req,
   wr_req_if.arbiter host_req,
   input fb_pkg::mem_addr_t read_addr,
   output fb_pkg::mem_addr_t mem_addr,
   output fb_pkg::mem_word_t mem_wdata,
   output logic mem_we
);
   import fb_pkg::*;

   logic write_slot;
   logic clear_win;
   logic host_win;
   mem_addr_t write_addr;
   logic [31:0] write_data;

   always_comb begin
      write_slot = (raster.hcount[1:0] == 2'(`FB_SLOT_WRITE));
      clear_win = write_slot && clear_req.valid;
      host_win = write_slot && host_req.valid && !clear_req.valid;

      // winner's address and data
      write_addr = clear_win ? clear_req.addr : host_req.addr;
      write_data = '0;
      if (clear_win) begin
         write_data = clear_req.data;
      end else if (host_win) begin
         write_data = host_req.data;
      end
   end

   // grants are single-cycle since each write slot lasts one clock
   assign clear_req.grant = clear_win;
   assign host_req.grant = host_win;

   assign mem_we = clear_win || host_win;
   assign mem_addr = mem_we ? write_addr : read_addr;
   // parity nibble is always written as zero
   assign mem_wdata = {4'h0, write_data};

   // the display read slot is never given to a write
   a_read_slot_free : assert property (@(posedge clk)
      (raster.hcount[1:0] == 2'(`FB_SLOT_READ)) |-> (!mem_we && (mem_addr == read_addr)))
      else $error("display read slot taken by a write");

endmodule

/* design/zbt_frame_buffer.sv */
////////////////////////////////////////
// frame buffer core, one clock domain
// memory port is a pipelined ZBT style
// horizontal total must be a multiple of 4
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module zbt_frame_buffer #(
   parameter int h_active = `FB_H_ACTIVE,
   parameter int h_front = `FB_H_FRONT,
   parameter int h_sync = `FB_H_SYNC,
   parameter int h_back = `FB_H_BACK,
   parameter int v_active = `FB_V_ACTIVE,
   parameter int v_front = `FB_V_FRONT,
   parameter int v_sync = `FB_V_SYNC,
   parameter int v_back = `FB_V_BACK
) (
   input logic clk,
   input logic reset,
   // apb slave
   input logic psel,
   input logic penable,
   input logic pwrite,
   input logic [3:0] paddr,
   input logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic pready,
   output logic pslverr,
   // memory port
   output fb_pkg::mem_addr_t mem_addr,
   output fb_pkg::mem_word_t mem_wdata,
   output logic mem_we,
   input fb_pkg::mem_word_t mem_rdata,
   // video
   output fb_pkg::pixel_t video_pixel,
   output logic video_hsync,
   output logic video_vsync,
   output logic video_blank
);
   import fb_pkg::*;

   localparam int h_total = h_active + h_front + h_sync + h_back;
   localparam int frame_words = h_active * v_active / 4;

   raster_if raster ();
   wr_req_if clear_req ();
   wr_req_if host_req ();

   mem_addr_t read_addr;
   offset_t offset;

   raster_timer #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
   ) u_raster_timer (
      .clk(clk), .reset(reset), .raster(raster)
   );

   clear_sequencer #(.frame_words(frame_words)) u_clear_sequencer (
      .clk(clk), .reset(reset), .offset(offset), .req(clear_req)
   );

   apb_pixel_port u_apb_pixel_port (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .offset(offset), .req(host_req)
   );

   slot_arbiter u_slot_arbiter (
      .clk(clk), .raster(raster), .clear_req(clear_req), .host_req(host_req),
      .read_addr(read_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_we(mem_we)
   );

   display_fetch #(.h_active(h_active), .h_total(h_total)) u_display_fetch (
      .clk(clk), .reset(reset), .raster(raster), .read_addr(read_addr),
      .mem_rdata(mem_rdata), .video_pixel(video_pixel), .video_hsync(video_hsync),
      .video_vsync(video_vsync), .video_blank(video_blank)
   );

endmodule

/* sim/tb_zbt_frame_buffer.sv */
////////////////////////////////////////
// tiny 16x4 raster so a frame is 196 clocks
// memory model holds 64 words only
// video is sampled on the rising edge
////////////////////////////////////////
`timescale 1ns/1ps
`include "fb_macros.svh"

module tb_zbt_frame_buffer;
   import fb_pkg::*;

   localparam int h_active = 16;
   localparam int h_front = 4;
   localparam int h_sync = 4;
   localparam int h_back = 4;
   localparam int v_active = 4;
   localparam int v_front = 1;
   localparam int v_sync = 1;
   localparam int v_back = 1;
   localparam int h_total = h_active + h_front + h_sync + h_back;
   localparam int v_total = v_active + v_front + v_sync + v_back;
   localparam int frame_cycles = h_total * v_total;
   localparam int frame_words = h_active * v_active / 4;
   localparam int frame_pixels = h_active * v_active;
   localparam int line_words = h_active / 4;
   localparam int clk_period = 40;
   // two frame checks, two clears and the register traffic fit in ten frames
   localparam int frames_used = 10;
   localparam int watchdog_cycles = frames_used * frame_cycles + 500;
   localparam int frame_limit = 3 * frame_cycles;
   localparam int access_limit = 1000;
   localparam int model_words = 64;

   logic clk;
   logic reset;
   logic psel;
   logic penable;
   logic pwrite;
   logic [3:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;
   mem_addr_t mem_addr;
   mem_word_t mem_wdata;
   logic mem_we;
   mem_word_t mem_rdata;
   pixel_t video_pixel;
   logic video_hsync;
   logic video_vsync;
   logic video_blank;

   // memory model and write log
   mem_word_t mem [0:model_words-1];
   mem_addr_t rd_pipe [0:`FB_READ_LATENCY-1];
   mem_addr_t log_addr [$];
   mem_word_t log_data [$];
   logic log_on;

   // what the frame should hold, kept from the register rules
   logic [31:0] exp_words [0:frame_words-1];
   offset_t cur_offset;
   mem_addr_t host_addr;
   int mismatches;
   int failures;
   int unsigned seed;

   zbt_frame_buffer #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
   ) u_dut (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
      .mem_rdata(mem_rdata), .video_pixel(video_pixel), .video_hsync(video_hsync),
      .video_vsync(video_vsync), .video_blank(video_blank)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // ZBT memory model
   ////////////////////////////////////////
   // fill differs at every address, parity set
   initial begin
      for (int i = 0; i < model_words; i++) begin
         mem[i] = {4'hf, 32'(i) * 32'h9e37_79b9};
      end
      foreach (rd_pipe[i]) begin
         rd_pipe[i] = '0;
      end
   end

   // read data appears FB_READ_LATENCY clocks after its address
   assign mem_rdata = mem[rd_pipe[`FB_READ_LATENCY-1][5:0]];

   always @(posedge clk) begin
      rd_pipe[0] <= mem_addr;
      for (int i = 1; i < `FB_READ_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
      if (mem_we) begin
         if (mem_addr < model_words) begin
            mem[mem_addr[5:0]] <= mem_wdata;
         end else begin
            $display("error: memory write to %h lies outside the model", mem_addr);
            failures++;
         end
      end
   end

   // write log, taken mid-cycle where the port is settled
   always @(negedge clk) begin
      if (log_on && mem_we) begin
         log_addr.push_back(mem_addr);
         log_data.push_back(mem_wdata);
      end
   end

   ////////////////////////////////////////
   // APB access tasks
   ////////////////////////////////////////
   task automatic apb_access(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic slverr, output int cycles);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= write;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      cycles = 0;
      // access phase lasts until pready
      do begin
         @(posedge clk);
         cycles++;
      end while (!pready && cycles < access_limit);
      if (!pready) begin
         $display("error: apb access to %h never completed", addr);
         failures++;
      end
      rdata = prdata;
      slverr = pslverr;
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   // register write that also tracks the expected frame
   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                            output int cycles);
      logic [31:0] rdata;
      logic slverr;
      apb_access(1'b1, addr, data, rdata, slverr, cycles);
      if (slverr) begin
         $display("mismatch at %0t: pslverr on write to %h", $time, addr);
         mismatches++;
      end
      if (addr != `FB_REG_DATA && cycles != 1) begin
         $display("mismatch at %0t: register write took %0d cycles", $time, cycles);
         mismatches++;
      end
      case (addr)
         `FB_REG_OFFSET: begin
            // a new offset zeroes the whole frame
            if (offset_t'(data) != cur_offset) begin
               foreach (exp_words[i]) begin
                  exp_words[i] = '0;
               end
            end
            cur_offset = offset_t'(data);
         end
         `FB_REG_ADDR: host_addr = mem_addr_t'(data);
         `FB_REG_DATA: begin
            if (host_addr < frame_words) begin
               exp_words[host_addr] = data;
            end
            host_addr++;
         end
         default: ;
      endcase
   endtask

   task automatic read_reg(input logic [3:0] addr, output logic [31:0] rdata,
                           output logic slverr);
      int cycles;
      apb_access(1'b0, addr, 32'h0, rdata, slverr, cycles);
   endtask

   // one full frame of active video against exp_words
   task automatic check_frame(input string what);
      int seen;
      int guard;
      int line;
      int col;
      int word;
      pixel_t want;
      seen = 0;
      guard = 0;
      // after the vsync pulse the next active line is line 0
      while (video_vsync && guard < frame_limit) begin
         @(posedge clk);
         guard++;
      end
      while (!video_vsync && guard < frame_limit) begin
         @(posedge clk);
         guard++;
      end
      while (seen < frame_pixels && guard < frame_limit) begin
         @(posedge clk);
         guard++;
         if (!video_blank) begin
            line = seen / h_active;
            col = seen % h_active;
            word = line * line_words + col / 4;
            // low byte is the leftmost pixel
            want = exp_words[word][8*(col%4) +: 8];
            if (video_pixel !== want) begin
               $display("mismatch at %0t: %s line %0d col %0d got %h expected %h",
                        $time, what, line, col, video_pixel, want);
               mismatches++;
            end
            seen++;
         end
      end
      if (seen < frame_pixels) begin
         $display("error: %s showed only %0d active pixels", what, seen);
         failures++;
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic check_reset_state();
      if (pready !== 1'b0 || pslverr !== 1'b0 || mem_we !== 1'b0) begin
         $display("mismatch at %0t: after reset pready %b pslverr %b mem_we %b",
                  $time, pready, pslverr, mem_we);
         mismatches++;
      end
      if (video_hsync !== 1'b1 || video_vsync !== 1'b1 || video_blank !== 1'b1) begin
         $display("mismatch at %0t: after reset hsync %b vsync %b blank %b",
                  $time, video_hsync, video_vsync, video_blank);
         mismatches++;
      end
   endtask

   task automatic check_registers();
      logic [31:0] rdata;
      logic slverr;
      int cycles;
      // offset keeps 6 bits
      write_reg(`FB_REG_OFFSET, 32'hffff_ff2a, cycles);
      read_reg(`FB_REG_OFFSET, rdata, slverr);
      if (rdata !== 32'h2a || slverr) begin
         $display("mismatch at %0t: offset read %h expected 0000002a", $time, rdata);
         mismatches++;
      end
      write_reg(`FB_REG_ADDR, 32'h0007_abcd, cycles);
      read_reg(`FB_REG_ADDR, rdata, slverr);
      if (rdata !== 32'h0007_abcd || slverr) begin
         $display("mismatch at %0t: address read %h expected 0007abcd", $time, rdata);
         mismatches++;
      end
      read_reg(4'hc, rdata, slverr);
      if (slverr !== 1'b1) begin
         $display("mismatch at %0t: read of unknown address gave no pslverr", $time);
         mismatches++;
      end
      read_reg(`FB_REG_DATA, rdata, slverr);
      if (slverr !== 1'b1) begin
         $display("mismatch at %0t: read of data register gave no pslverr", $time);
         mismatches++;
      end
      apb_access(1'b1, 4'hc, 32'h1234_5678, rdata, slverr, cycles);
      if (slverr !== 1'b1) begin
         $display("mismatch at %0t: write to unknown address gave no pslverr", $time);
         mismatches++;
      end
   endtask

   task automatic check_data_writes();
      logic [31:0] data [0:3];
      logic [31:0] rdata;
      logic slverr;
      int cycles;
      write_reg(`FB_REG_ADDR, 32'd8, cycles);
      for (int i = 0; i < 4; i++) begin
         data[i] = $urandom;
         write_reg(`FB_REG_DATA, data[i], cycles);
      end
      // model takes the last write on the edge that ended its access
      @(posedge clk);
      for (int i = 0; i < 4; i++) begin
         if (mem[8+i] !== {4'h0, data[i]}) begin
            $display("mismatch at %0t: word %0d holds %h expected %h",
                     $time, 8 + i, mem[8+i], {4'h0, data[i]});
            mismatches++;
         end
      end
      read_reg(`FB_REG_ADDR, rdata, slverr);
      if (rdata !== 32'd12) begin
         $display("mismatch at %0t: address after writes %h expected 12", $time, rdata);
         mismatches++;
      end
   endtask

   task automatic check_display();
      int cycles;
      write_reg(`FB_REG_ADDR, 32'd0, cycles);
      for (int w = 0; w < frame_words; w++) begin
         write_reg(`FB_REG_DATA, $urandom, cycles);
      end
      check_frame("random frame");
   endtask

   task automatic check_clear();
      logic [31:0] data;
      int cycles;
      write_reg(`FB_REG_ADDR, 32'd5, cycles);
      log_addr.delete();
      log_data.delete();
      log_on = 1'b1;
      write_reg(`FB_REG_OFFSET, 32'h15, cycles);
      data = $urandom;
      // this write has to wait behind the clear
      write_reg(`FB_REG_DATA, data, cycles);
      log_on = 1'b0;
      if (cycles <= 4) begin
         $display("mismatch at %0t: data write during clear took %0d cycles", $time, cycles);
         mismatches++;
      end
      if (log_addr.size() != frame_words + 1) begin
         $display("mismatch at %0t: %0d memory writes, expected %0d",
                  $time, log_addr.size(), frame_words + 1);
         mismatches++;
      end else begin
         for (int i = 0; i < frame_words; i++) begin
            if (log_addr[i] !== mem_addr_t'(i) || log_data[i] !== '0) begin
               $display("mismatch at %0t: clear write %0d went to %h with %h",
                        $time, i, log_addr[i], log_data[i]);
               mismatches++;
            end
         end
         if (log_addr[frame_words] !== 5 || log_data[frame_words] !== {4'h0, data}) begin
            $display("mismatch at %0t: host write after clear went to %h with %h",
                     $time, log_addr[frame_words], log_data[frame_words]);
            mismatches++;
         end
      end
      check_frame("frame after clear");
      // same offset again, so no clear and no wait
      log_addr.delete();
      log_data.delete();
      log_on = 1'b1;
      write_reg(`FB_REG_OFFSET, 32'h15, cycles);
      write_reg(`FB_REG_DATA, $urandom, cycles);
      repeat (8) @(posedge clk);
      log_on = 1'b0;
      if (cycles > 4 || log_addr.size() != 1) begin
         $display("mismatch at %0t: same offset gave %0d writes, data write %0d cycles",
                  $time, log_addr.size(), cycles);
         mismatches++;
      end
   endtask

   ////////////////////////////////////////
   // run control
   ////////////////////////////////////////
   initial begin
      seed = 32'h7e78;
      void'($urandom(seed));
      mismatches = 0;
      failures = 0;
      log_on = 1'b0;
      cur_offset = '0;
      host_addr = '0;
      foreach (exp_words[i]) begin
         exp_words[i] = '0;
      end
      reset <= 1'b1;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      check_reset_state();
      check_registers();
      check_data_writes();
      check_display();
      check_clear();
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // watchdog sized from the frames the tests use
   initial begin
      #(watchdog_cycles * clk_period);
      $display("error: watchdog expired after %0d cycles, tests did not finish",
               watchdog_cycles);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
      $display("sim failed");
      $finish;
   end

endmodule

/* zbt_frame_buffer.f */
+incdir+design
design/fb_pkg.sv
design/fb_ifs.sv
design/raster_timer.sv
design/clear_sequencer.sv
design/apb_pixel_port.sv
design/slot_arbiter.sv
design/display_fetch.sv
design/zbt_frame_buffer.sv
sim/tb_zbt_frame_buffer.sv
